//--- Makefile
SIM  := obj_dir/Vtb_hazard_pipe
SRCS := $(shell grep -v '^+' sim.f) verilog/pipe_consts.svh

.PHONY: all run clean

all: run

$(SIM): sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_hazard_pipe \
		-f sim.f -o Vtb_hazard_pipe

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/instr_decode.sv
verilog/hazard_unit.sv
verilog/pipe_reg.sv
verilog/fetch_stage.sv
verilog/hazard_pipe_top.sv
tb/tb_hazard_pipe.sv

//--- tb/tb_hazard_pipe.sv
`timescale 1ns/1ps
`include "pipe_consts.svh"

module tb_hazard_pipe;

	import isa_pkg::*;

	localparam int NUM_ROWS   = 9;
	localparam int WINDOW     = 6;                  // cycles watched after the second word
	localparam int MAX_CYCLES = NUM_ROWS * 12 + 60;

	logic               clk;
	logic               arst_n;
	logic [`WORD_W-1:0] instr;
	logic               flush;
	logic [`WORD_W-1:0] flush_target;
	logic [`WORD_W-1:0] pc;
	logic               stall;
	logic               hlt_out;
	logic               halted;
	logic [`WORD_W-1:0] ex_instr;
	logic               ex_valid;

	// scenario table, one entry per index
	string              row_name   [NUM_ROWS];
	logic [`WORD_W-1:0] row_first  [NUM_ROWS];
	logic [`WORD_W-1:0] row_second [NUM_ROWS];
	int                 row_stalls [NUM_ROWS];
	int                 row_count;

	int errors;
	int checks;
	int cycle_cnt = 0;

	logic [`WORD_W-1:0] filler;     // B, reads no registers
	logic [`WORD_W-1:0] hlt_word;

	hazard_pipe_top UUT (
		.clk          (clk),
		.arst_n       (arst_n),
		.instr        (instr),
		.flush        (flush),
		.flush_target (flush_target),
		.pc           (pc),
		.stall        (stall),
		.hlt_out      (hlt_out),
		.halted       (halted),
		.ex_instr     (ex_instr),
		.ex_valid     (ex_valid)
	);

	// *************************************************
	// clock, cycle count, timeout
	// *************************************************
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period
	end

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	initial begin
		while (cycle_cnt < MAX_CYCLES) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// *************************************************
	// helpers
	// *************************************************
	// opcode, 11:8, 7:4, 3:0
	function automatic logic [`WORD_W-1:0] encode(opcode_e op, logic [3:0] f2,
			logic [3:0] f1, logic [3:0] f0);
		return {op, f2, f1, f0};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic add_row(input string name, input logic [`WORD_W-1:0] first,
			input logic [`WORD_W-1:0] second, input int stalls);
		row_name[row_count]   = name;
		row_first[row_count]  = first;
		row_second[row_count] = second;
		row_stalls[row_count] = stalls;
		row_count++;
	endtask

	task automatic fill_rows();
		row_count = 0;
		// load r3 from base r1, then a consumer
		add_row("lw_rs_match",    encode(OP_LW, 3, 1, 0),  encode(OP_ADD, 5, 3, 2), 1);
		add_row("lw_rt_match",    encode(OP_LW, 3, 1, 0),  encode(OP_SUB, 5, 2, 3), 1);
		add_row("lw_sw_data",     encode(OP_LW, 3, 1, 0),  encode(OP_SW, 3, 1, 0),  1);
		add_row("lw_sw_base",     encode(OP_LW, 3, 1, 0),  encode(OP_SW, 5, 3, 0),  1);
		add_row("lw_lhb",         encode(OP_LW, 3, 1, 0),  encode(OP_LHB, 3, 15, 15), 1);
		add_row("lw_lw_base",     encode(OP_LW, 3, 1, 0),  encode(OP_LW, 6, 3, 0),  1);
		add_row("alu_producer",   encode(OP_ADD, 3, 1, 2), encode(OP_ADD, 5, 3, 2), 0);
		add_row("lw_no_match",    encode(OP_LW, 3, 1, 0),  encode(OP_ADD, 5, 4, 2), 0);
		add_row("lw_ctrl_consumer", encode(OP_LW, 3, 1, 0), encode(OP_B, 3, 3, 3),  0);
	endtask

	task automatic apply_reset();
		arst_n = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		check_value("reset pc", `RESET_PC, pc);
		check_value("reset stall", 0, stall);
		check_value("reset hlt_out", 0, hlt_out);
		check_value("reset halted", 0, halted);
		check_value("reset ex_valid", 0, ex_valid);
	endtask

	// flush to base, then feed two words and watch the window
	task automatic run_row(input int idx, input int base);
		int stall_cnt;
		int k;
		int pc_exp;
		@(negedge clk);
		flush        = 1'b1;
		flush_target = 16'(base);
		instr        = filler;
		@(negedge clk);
		check_value({row_name[idx], " redirect pc"}, base, pc);
		check_value({row_name[idx], " ex empty after flush"}, 0, ex_valid);
		flush = 1'b0;
		instr = row_first[idx];
		@(negedge clk);
		check_value({row_name[idx], " ex still empty"}, 0, ex_valid);
		stall_cnt = stall;            // first word in decode, EX empty
		instr     = row_second[idx];
		for (k = 0; k < WINDOW; k++) begin
			@(negedge clk);
			if (stall)
				stall_cnt++;
			// pc loses one step during a stall cycle
			pc_exp = base + 2 + k - ((k >= 1) ? row_stalls[idx] : 0);
			check_value({row_name[idx], " pc"}, pc_exp, pc);
			if (k == 0) begin
				check_value({row_name[idx], " ex first word"}, row_first[idx], ex_instr);
				check_value({row_name[idx], " ex first valid"}, 1, ex_valid);
			end
			if (row_stalls[idx] == 1 && k == 1)
				check_value({row_name[idx], " ex bubble"}, 0, ex_valid);
			if (k == 1 + row_stalls[idx]) begin
				check_value({row_name[idx], " ex second word"}, row_second[idx], ex_instr);
				check_value({row_name[idx], " ex second valid"}, 1, ex_valid);
			end
			instr = filler;
		end
		check_value({row_name[idx], " stall cycles"}, row_stalls[idx], stall_cnt);
	endtask

	// *************************************************
	// halt scenarios
	// *************************************************
	// flush one cycle after the HLT reaches IF/ID
	task automatic halt_squashed(input int base);
		int k;
		@(negedge clk);
		flush        = 1'b1;
		flush_target = 16'(base);
		instr        = filler;
		@(negedge clk);
		flush = 1'b0;
		instr = hlt_word;
		@(negedge clk);               // HLT sits in decode
		instr        = filler;
		flush        = 1'b1;
		flush_target = 16'(base + 8);
		@(negedge clk);
		flush = 1'b0;
		check_value("squash redirect pc", base + 8, pc);
		for (k = 0; k < `HLT_DELAY + 3; k++) begin
			@(negedge clk);
			check_value("squash hlt_out", 0, hlt_out);
			check_value("squash halted", 0, halted);
		end
	endtask

	task automatic halt_run(input int base);
		int edges;
		int k;
		logic [`WORD_W-1:0] frozen_pc;
		@(negedge clk);
		flush        = 1'b1;
		flush_target = 16'(base);
		instr        = filler;
		@(negedge clk);
		flush = 1'b0;
		instr = hlt_word;
		edges = 0;
		do begin
			@(negedge clk);
			instr = filler;
			edges++;
		end while (!hlt_out && edges < 10);
		checks++;
		assert (hlt_out) else begin
			$display("hlt_out never pulsed after the HLT word");
			errors++;
		end
		// capture edge plus the delay line
		check_value("halt pulse edge", `HLT_DELAY + 1, edges);
		check_value("halted before pulse edge", 0, halted);
		@(negedge clk);
		check_value("hlt_out single pulse", 0, hlt_out);
		check_value("halted set", 1, halted);
		frozen_pc = pc;
		check_value("halt pc", base + `HLT_DELAY + 2, frozen_pc);
		for (k = 0; k < 4; k++) begin
			@(negedge clk);
			check_value("halt stall", 1, stall);
			check_value("halt pc frozen", frozen_pc, pc);
			check_value("halt no pulse", 0, hlt_out);
			check_value("halt ex empty", 0, ex_valid);
		end
		// redirect still works, halt stays
		flush        = 1'b1;
		flush_target = 16'(base + 32);
		@(negedge clk);
		flush = 1'b0;
		check_value("halted flush pc", base + 32, pc);
		check_value("flush keeps halted", 1, halted);
		@(negedge clk);
		check_value("halted pc after flush", base + 32, pc);
	endtask

	// *************************************************
	// main sequence
	// *************************************************
	initial begin
		int i;
		arst_n       = 1'b0;
		filler       = encode(OP_B, 0, 0, 0);
		hlt_word     = encode(OP_HLT, 0, 0, 0);
		instr        = filler;
		flush        = 1'b0;
		flush_target = '0;
		errors       = 0;
		checks       = 0;
		fill_rows();
		apply_reset();
		for (i = 0; i < row_count; i++)
			run_row(i, 'h100 + i * 'h10);   // own address range per row
		halt_squashed('h400);
		halt_run('h500);                  // last, halted is sticky
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps
`include "pipe_consts.svh"

module fetch_stage (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               stall,
	input  logic               halted,
	input  logic               flush,
	input  logic [`WORD_W-1:0] flush_target,
	output logic [`WORD_W-1:0] pc
);

	logic               freeze;    // no advance this edge
	logic [`WORD_W-1:0] pc_next;

	assign freeze = stall | halted;

	// *************************************************
	// next pc, priority flush > freeze > increment
	// *************************************************
	always_comb begin
		if (flush) begin
			pc_next = flush_target;     // redirect
		end else if (freeze) begin
			pc_next = pc;               // hold for hazard or halt
		end else begin
			pc_next = pc + 1'b1;        // one word per instruction
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= `RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// a halted core only moves on a redirect
	a_halt_freeze: assert property (
		@(posedge clk) disable iff (!arst_n)
		(halted && !flush) |=> $stable(pc)
	);

endmodule

//--- verilog/hazard_pipe_top.sv
`timescale 1ns/1ps
`include "pipe_consts.svh"

module hazard_pipe_top (
	input  logic               clk,
	input  logic               arst_n,
	input  logic [`WORD_W-1:0] instr,          // word at the current pc
	input  logic               flush,          // one cycle strobe
	input  logic [`WORD_W-1:0] flush_target,
	output logic [`WORD_W-1:0] pc,
	output logic               stall,
	output logic               hlt_out,
	output logic               halted,
	output logic [`WORD_W-1:0] ex_instr,
	output logic               ex_valid
);

	import isa_pkg::*;
	import pipe_pkg::*;

	if_id_t   if_id_d, if_id_q;
	id_ex_t   id_ex_d, id_ex_q;

	reg_idx_t id_rs, id_rt;
	logic     id_uses_rs, id_uses_rt;
	logic     id_is_load, id_is_hlt;
	reg_idx_t ex_rd;

	// *************************************************
	// fetch and IF/ID
	// *************************************************
	fetch_stage u_fetch (
		.clk          (clk),
		.arst_n       (arst_n),
		.stall        (stall),
		.halted       (halted),
		.flush        (flush),
		.flush_target (flush_target),
		.pc           (pc)
	);

	assign if_id_d = '{valid: 1'b1, instr: instr, pc: pc};

	pipe_reg #(.payload_t(if_id_t)) u_if_id (
		.clk    (clk),
		.arst_n (arst_n),
		.hold   (stall),   // dependent word waits here
		.bubble (flush),
		.d      (if_id_d),
		.q      (if_id_q)
	);

	instr_decode u_id_dec (
		.instr   (if_id_q.instr),
		.valid   (if_id_q.valid),
		.rs      (id_rs),
		.rt      (id_rt),
		.rd      (),
		.uses_rs (id_uses_rs),
		.uses_rt (id_uses_rt),
		.is_load (id_is_load),
		.is_hlt  (id_is_hlt)
	);

	// *************************************************
	// ID/EX
	// *************************************************
	assign id_ex_d = '{valid: if_id_q.valid, instr: if_id_q.instr, mem_to_reg: id_is_load};

	pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk    (clk),
		.arst_n (arst_n),
		.hold   (1'b0),            // execute never waits
		.bubble (flush | stall),   // stall inserts the empty slot
		.d      (id_ex_d),
		.q      (id_ex_q)
	);

	instr_decode u_ex_dec (
		.instr   (id_ex_q.instr),
		.valid   (id_ex_q.valid),
		.rs      (),
		.rt      (),
		.rd      (ex_rd),
		.uses_rs (),
		.uses_rt (),
		.is_load (),
		.is_hlt  ()
	);

	hazard_unit u_hazard (
		.clk        (clk),
		.arst_n     (arst_n),
		.flush      (flush),
		.id_rs      (id_rs),
		.id_rt      (id_rt),
		.ex_rd      (ex_rd),
		.id_uses_rs (id_uses_rs),
		.id_uses_rt (id_uses_rt),
		.ex_is_load (id_ex_q.mem_to_reg),   // carried flag cleared by a bubble
		.id_is_hlt  (id_is_hlt),
		.stall      (stall),
		.hlt_out    (hlt_out),
		.halted     (halted)
	);

	assign ex_instr = id_ex_q.instr;
	assign ex_valid = id_ex_q.valid;

endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/1ps
`include "pipe_consts.svh"

module hazard_unit (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              flush,
	input  isa_pkg::reg_idx_t id_rs,
	input  isa_pkg::reg_idx_t id_rt,
	input  isa_pkg::reg_idx_t ex_rd,
	input  logic              id_uses_rs,
	input  logic              id_uses_rt,
	input  logic              ex_is_load,
	input  logic              id_is_hlt,
	output logic              stall,
	output logic              hlt_out,
	output logic              halted
);

	import isa_pkg::*;

	logic                  rs_hit;     // decode rs needs the load result
	logic                  rt_hit;     // decode rt needs the load result
	logic                  load_use;   // one cycle bubble needed
	logic                  hlt_take;   // HLT leaving decode this edge
	logic [`HLT_DELAY-1:0] hlt_line;   // halt delay line, bit 0 first

	// *************************************************
	// load-use detection
	// *************************************************
	assign rs_hit   = id_uses_rs && (id_rs == ex_rd);
	assign rt_hit   = id_uses_rt && (id_rt == ex_rd);
	assign load_use = ex_is_load && (rs_hit || rt_hit);

	// the ID/EX bubble on the next edge removes the load
	// so the stall drops by itself after one cycle
	assign stall = load_use | halted;

	// *************************************************
	// halt delay line
	// *************************************************
	// a stalled HLT stays in decode, sample it only once
	assign hlt_take = id_is_hlt && !stall;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hlt_line <= '0;
		end else if (flush) begin
			hlt_line <= '0;                                  // squashed HLT never fires
		end else begin
			hlt_line <= {hlt_line[`HLT_DELAY-2:0], hlt_take}; // shift toward the output
		end
	end

	assign hlt_out = hlt_line[`HLT_DELAY-1];   // pulse at the end of the line

	// sticky, only reset clears it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			halted <= 1'b0;
		end else if (hlt_out) begin
			halted <= 1'b1;
		end
	end

	// *************************************************
	// checks
	// *************************************************
	// relies on the ID/EX register taking a bubble
	a_stall_one_cycle: assert property (
		@(posedge clk) disable iff (!arst_n)
		(stall && !halted) |=> (!stall || halted)
	);

	// one HLT gives one pulse
	a_hlt_pulse: assert property (
		@(posedge clk) disable iff (!arst_n)
		hlt_out |=> !hlt_out
	);

endmodule

//--- verilog/instr_decode.sv
`timescale 1ns/1ps
`include "pipe_consts.svh"

module instr_decode (
	input  logic [`WORD_W-1:0] instr,
	input  logic               valid,
	output isa_pkg::reg_idx_t  rs,
	output isa_pkg::reg_idx_t  rt,
	output isa_pkg::reg_idx_t  rd,
	output logic               uses_rs,
	output logic               uses_rt,
	output logic               is_load,
	output logic               is_hlt
);

	import isa_pkg::*;

	opcode_e op;
	logic    is_alu;    // opcodes 0..7
	logic    is_store;
	logic    is_byte;   // LHB or LLB
	logic    has_src;   // any register read at all

	assign op = opcode_e'(instr[15:12]);

	// *************************************************
	// opcode classes
	// *************************************************
	assign is_alu   = ~instr[15];            // top bit clear for alu group
	assign is_store = (op == OP_SW);
	assign is_byte  = (op == OP_LHB) || (op == OP_LLB);
	// control ops and HLT read nothing
	assign has_src  = is_alu || (op == OP_LW) || is_store || is_byte;

	// *************************************************
	// register fields
	// *************************************************
	assign rd = instr[11:8];   // destination always here

	// store data and byte loads read the 11:8 field
	assign rs = (is_store || is_byte) ? instr[11:8] : instr[7:4];
	// memory ops keep the base in 7:4
	assign rt = (is_store || (op == OP_LW)) ? instr[7:4] : instr[3:0];

	// flags gated by valid so a bubble reports nothing
	assign uses_rs = valid && has_src;
	assign uses_rt = valid && (is_alu || (op == OP_LW) || is_store); // byte loads carry an immediate
	assign is_load = valid && (op == OP_LW);
	assign is_hlt  = valid && (op == OP_HLT);

endmodule

//--- verilog/isa_pkg.sv
`include "pipe_consts.svh"

package isa_pkg;

	// opcode lives in instr[15:12]
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,   // register alu ops start here
		OP_SUB  = 4'd1,
		OP_XOR  = 4'd2,
		OP_RED  = 4'd3,
		OP_SLL  = 4'd4,
		OP_SRA  = 4'd5,
		OP_ROR  = 4'd6,
		OP_PADD = 4'd7,   // last alu op
		OP_LW   = 4'd8,   // load word, rd <- mem
		OP_SW   = 4'd9,   // store word, data in 11:8
		OP_LHB  = 4'd10,  // load high byte, reads rd
		OP_LLB  = 4'd11,  // load low byte, reads rd
		OP_B    = 4'd12,  // control group, no register sources
		OP_BR   = 4'd13,
		OP_PCS  = 4'd14,
		OP_HLT  = 4'd15   // stop the machine
	} opcode_e;

	// register file index
	typedef logic [`REG_IDX_W-1:0] reg_idx_t;

endpackage

//--- verilog/pipe_consts.svh
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// *************************************************
// datapath widths
// *************************************************
`define WORD_W     16        // instruction word and pc
`define REG_IDX_W  4         // 16 architectural registers

// *************************************************
// control constants
// *************************************************
// edges between HLT leaving decode and the hlt_out pulse
`define HLT_DELAY  3
`define RESET_PC   16'h0000  // first fetch address

`endif

//--- verilog/pipe_pkg.sv
`include "pipe_consts.svh"

package pipe_pkg;

	// *************************************************
	// IF/ID payload, 33 bits
	// *************************************************
	typedef struct packed {
		logic              valid;  // cleared by a bubble
		logic [`WORD_W-1:0] instr; // fetched word
		logic [`WORD_W-1:0] pc;    // its address
	} if_id_t;

	// *************************************************
	// ID/EX payload, 18 bits
	// *************************************************
	typedef struct packed {
		logic              valid;      // cleared by a bubble
		logic [`WORD_W-1:0] instr;     // word moving into execute
		logic              mem_to_reg; // load result goes to rd
	} id_ex_t;

endpackage

//--- verilog/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     hold,     // keep current contents
	input  logic     bubble,   // load an empty slot
	input  payload_t d,
	output payload_t q
);

	// all-zero payload also clears valid
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (bubble) begin
			q <= '0;      // flush beats hold
		end else if (!hold) begin
			q <= d;
		end
	end

	// held stage keeps its word across the edge
	a_hold_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		(hold && !bubble) |=> $stable(q)
	);

endmodule
